// ==== common/rvPkg.sv ====
// ==================================================
// Shared types and constants for the RV32I core
// Opcodes, ALU operations, writeback sources and
// the memory map of the system
// ==================================================
`default_nettype none

package rvPkg;

   localparam int XLEN = 32;

   // Memory sizes in words
   localparam int IMEM_WORDS = 256;
   localparam int DMEM_WORDS = 256;
   localparam int IMEM_AW = $clog2(IMEM_WORDS);
   localparam int DMEM_AW = $clog2(DMEM_WORDS);

   // Memory-mapped I/O ports
   localparam logic [XLEN-1:0] IO_OUT_ADDR = 32'h8000_0000;
   localparam logic [XLEN-1:0] IO_IN_ADDR = 32'h8000_0004;

   localparam logic [XLEN-1:0] RESET_PC = '0;

   // addi x0, x0, 0
   localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

   typedef enum logic [6:0] {
      opcOp    = 7'b0110011,
      opcOpImm = 7'b0010011,
      opcLui   = 7'b0110111,
      opcAuipc = 7'b0010111,
      opcBranch = 7'b1100011,
      opcJal   = 7'b1101111,
      opcJalr  = 7'b1100111,
      opcLoad  = 7'b0000011,
      opcStore = 7'b0100011
   } opcodeT;

   typedef enum logic [3:0] {
      aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor,
      aluSrl, aluSra, aluOr, aluAnd, aluPassB
   } aluOpT;

   typedef enum logic [1:0] {wbAlu, wbMem, wbPcPlus4} wbSrcT;

endpackage

`default_nettype wire

// ==== hdl/regFile.sv ====
// ==================================================
// Register file, 32 x 32 bits
// Two asynchronous reads, one synchronous write,
// x0 reads as zero
// ==================================================
`default_nettype none

module regFile (
   input wire logic clk,
   input wire logic [4:0] ra1,
   input wire logic [4:0] ra2,
   output logic [rvPkg::XLEN-1:0] rd1,
   output logic [rvPkg::XLEN-1:0] rd2,
   input wire logic we,
   input wire logic [4:0] wa,
   input wire logic [rvPkg::XLEN-1:0] wd
);
   logic [rvPkg::XLEN-1:0] regs [32];

   always_ff @(posedge clk)
   begin
      if (we && wa != 5'd0)
         regs[wa] <= wd;
   end

   // Write-through so a value written this cycle is visible to execute
   assign rd1 = (ra1 == 5'd0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
   assign rd2 = (ra2 == 5'd0) ? '0 : (we && wa == ra2) ? wd : regs[ra2];

endmodule

`default_nettype wire

// ==== core/decoder.sv ====
// ==================================================
// Instruction decoder
// Splits fields, builds the immediate and drives
// the control signals of the execute stage
// ==================================================
`default_nettype none

module decoder (
   input wire logic [rvPkg::XLEN-1:0] instr,
   output logic [4:0] rs1,
   output logic [4:0] rs2,
   output logic [4:0] rd,
   output logic [rvPkg::XLEN-1:0] imm,
   output rvPkg::aluOpT aluOp,
   output logic aluSrcImm,
   output logic aluSrcPc,
   output logic regWrite,
   output logic memRead,
   output logic memWrite,
   output logic isBranch,
   output logic isJal,
   output logic isJalr,
   output logic [2:0] funct3,
   output rvPkg::wbSrcT wbSrc
);
   import rvPkg::*;

   opcodeT opc;
   aluOpT arithOp;
   logic [XLEN-1:0] immI, immS, immB, immU, immJ;

   assign opc = opcodeT'(instr[6:0]);
   assign rs1 = instr[19:15];
   assign rs2 = instr[24:20];
   assign rd = instr[11:7];
   assign funct3 = instr[14:12];

   assign immI = {{20{instr[31]}}, instr[31:20]};
   assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
   assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
   assign immU = {instr[31:12], 12'b0};
   assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

   // Shared by register and immediate forms; sub only exists in OP
   always_comb
   begin
      case (funct3)
         3'd0: arithOp = (opc == opcOp && instr[30]) ? aluSub : aluAdd;
         3'd1: arithOp = aluSll;
         3'd2: arithOp = aluSlt;
         3'd3: arithOp = aluSltu;
         3'd4: arithOp = aluXor;
         3'd5: arithOp = instr[30] ? aluSra : aluSrl;
         3'd6: arithOp = aluOr;
         default: arithOp = aluAnd;
      endcase
   end

   always_comb
   begin
      // Defaults describe a NOP
      imm = '0;
      aluOp = aluAdd;
      aluSrcImm = 1'b0;
      aluSrcPc = 1'b0;
      regWrite = 1'b0;
      memRead = 1'b0;
      memWrite = 1'b0;
      isBranch = 1'b0;
      isJal = 1'b0;
      isJalr = 1'b0;
      wbSrc = wbAlu;
      case (opc)
         opcOp:
         begin
            regWrite = 1'b1;
            aluOp = arithOp;
         end
         opcOpImm:
         begin
            regWrite = 1'b1;
            aluSrcImm = 1'b1;
            aluOp = arithOp;
            imm = immI;
         end
         opcLui:
         begin
            regWrite = 1'b1;
            aluSrcImm = 1'b1;
            aluOp = aluPassB;
            imm = immU;
         end
         opcAuipc:
         begin
            regWrite = 1'b1;
            aluSrcImm = 1'b1;
            aluSrcPc = 1'b1;
            imm = immU;
         end
         opcBranch:
         begin
            isBranch = 1'b1;
            imm = immB;
         end
         opcJal:
         begin
            isJal = 1'b1;
            regWrite = 1'b1;
            wbSrc = wbPcPlus4;
            imm = immJ;
         end
         opcJalr:
         begin
            isJalr = 1'b1;
            regWrite = 1'b1;
            wbSrc = wbPcPlus4;
            imm = immI;
         end
         opcLoad:
         begin
            regWrite = 1'b1;
            memRead = 1'b1;
            aluSrcImm = 1'b1;
            wbSrc = wbMem;
            imm = immI;
         end
         opcStore:
         begin
            memWrite = 1'b1;
            aluSrcImm = 1'b1;
            imm = immS;
         end
         default:
         begin
            regWrite = 1'b0;
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== core/aluUnit.sv ====
// ==================================================
// Combinational ALU
// Arithmetic, logic, shift and compare operations
// ==================================================
`default_nettype none

module aluUnit (
   input wire logic [rvPkg::XLEN-1:0] a,
   input wire logic [rvPkg::XLEN-1:0] b,
   input wire rvPkg::aluOpT op,
   output logic [rvPkg::XLEN-1:0] result
);
   import rvPkg::*;

   logic [4:0] shamt;

   // Only the low five bits count as a shift amount
   assign shamt = b[4:0];

   always_comb
   begin
      case (op)
         aluAdd: result = a + b;
         aluSub: result = a - b;
         aluSll: result = a << shamt;
         aluSlt: result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
         aluSltu: result = {{(XLEN-1){1'b0}}, a < b};
         aluXor: result = a ^ b;
         aluSrl: result = a >> shamt;
         aluSra: result = $signed(a) >>> shamt;
         aluOr: result = a | b;
         aluAnd: result = a & b;
         aluPassB: result = b;
         default: result = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== core/branchUnit.sv ====
// ==================================================
// Branch unit
// Resolves branch conditions and jump targets
// ==================================================
`default_nettype none

module branchUnit (
   input wire logic [rvPkg::XLEN-1:0] a,
   input wire logic [rvPkg::XLEN-1:0] b,
   input wire logic [2:0] funct3,
   input wire logic [rvPkg::XLEN-1:0] pc,
   input wire logic [rvPkg::XLEN-1:0] imm,
   input wire logic isBranch,
   input wire logic isJal,
   input wire logic isJalr,
   output logic taken,
   output logic [rvPkg::XLEN-1:0] target
);
   logic cond;

   always_comb
   begin
      case (funct3)
         3'b000: cond = (a == b);
         3'b001: cond = (a != b);
         3'b100: cond = ($signed(a) < $signed(b));
         3'b101: cond = ($signed(a) >= $signed(b));
         3'b110: cond = (a < b);
         3'b111: cond = (a >= b);
         default: cond = 1'b0;
      endcase
   end

   assign taken = isJal || isJalr || (isBranch && cond);
   // JALR drops bit 0 of the computed address
   assign target = isJalr ? ((a + imm) & ~32'd1) : (pc + imm);

endmodule

`default_nettype wire

// ==== core/riscCore.sv ====
// ==================================================
// Three-stage RV32I core
// Fetch, execute and writeback with writeback
// forwarding, one-cycle branch flush and stall
// ==================================================
`default_nettype none

module riscCore (
   input wire logic clk,
   input wire logic rst,
   output logic [rvPkg::XLEN-1:0] imemAddr,
   input wire logic [rvPkg::XLEN-1:0] imemData,
   output logic [rvPkg::XLEN-1:0] dmemAddr,
   output logic [rvPkg::XLEN-1:0] dmemWData,
   output logic dmemWe,
   output logic dmemRe,
   input wire logic [rvPkg::XLEN-1:0] dmemRData,
   input wire logic stall
);
   import rvPkg::*;

   // Fetch state
   logic [XLEN-1:0] pc, nextPc;
   // Execute state
   logic [XLEN-1:0] pcExe, instrExe;
   logic exeValid;
   // Decoded controls
   logic [4:0] rs1, rs2, rd;
   logic [XLEN-1:0] imm;
   aluOpT aluOp;
   wbSrcT wbSrc;
   logic [2:0] funct3;
   logic aluSrcImm, aluSrcPc, regWrite, memRead, memWrite;
   logic isBranch, isJal, isJalr;
   // Datapath
   logic [XLEN-1:0] rd1, rd2, opA, opB, aluResult, target;
   logic taken;
   // Writeback state
   logic wbRegWrite;
   logic [4:0] wbRd;
   wbSrcT wbSrcReg;
   logic [XLEN-1:0] wbAluRes, wbLink, wbValue;

   // Slot behind a taken branch, or after reset, executes as a NOP
   assign instrExe = exeValid ? imemData : NOP_INSTR;

   decoder dec (
      .instr(instrExe), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .aluOp(aluOp),
      .aluSrcImm(aluSrcImm), .aluSrcPc(aluSrcPc), .regWrite(regWrite),
      .memRead(memRead), .memWrite(memWrite), .isBranch(isBranch), .isJal(isJal),
      .isJalr(isJalr), .funct3(funct3), .wbSrc(wbSrc)
   );

   // Bypass inside the register file forwards the writeback value
   regFile regs (
      .clk(clk), .ra1(rs1), .ra2(rs2), .rd1(rd1), .rd2(rd2),
      .we(wbRegWrite), .wa(wbRd), .wd(wbValue)
   );

   assign opA = aluSrcPc ? pcExe : rd1;
   assign opB = aluSrcImm ? imm : rd2;

   aluUnit alu (.a(opA), .b(opB), .op(aluOp), .result(aluResult));

   branchUnit bru (
      .a(rd1), .b(rd2), .funct3(funct3), .pc(pcExe), .imm(imm),
      .isBranch(isBranch), .isJal(isJal), .isJalr(isJalr),
      .taken(taken), .target(target)
   );

   assign nextPc = taken ? target : pc + 32'd4;
   assign imemAddr = pc;
   assign dmemAddr = aluResult;
   assign dmemWData = rd2;
   assign dmemWe = memWrite;
   assign dmemRe = memRead;

   always_comb
   begin
      case (wbSrcReg)
         wbMem: wbValue = dmemRData;
         wbPcPlus4: wbValue = wbLink;
         default: wbValue = wbAluRes;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pc <= RESET_PC;
         exeValid <= 1'b0;
         wbRegWrite <= 1'b0;
      end
      else if (!stall)
      begin
         pc <= nextPc;
         exeValid <= !taken;
         wbRegWrite <= regWrite;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!stall)
      begin
         pcExe <= pc;
         wbRd <= rd;
         wbSrcReg <= wbSrc;
         wbAluRes <= aluResult;
         wbLink <= pcExe + 32'd4;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/memSystem.sv ====
// ==================================================
// Memory system
// Instruction ROM, data RAM and the two four-phase
// I/O ports, with pipeline stall
// ==================================================
`default_nettype none

module memSystem (
   input wire logic clk,
   input wire logic rst,
   input wire logic [rvPkg::XLEN-1:0] imemAddr,
   output logic [rvPkg::XLEN-1:0] imemData,
   input wire logic [rvPkg::XLEN-1:0] dmemAddr,
   input wire logic [rvPkg::XLEN-1:0] dmemWData,
   input wire logic dmemWe,
   input wire logic dmemRe,
   output logic [rvPkg::XLEN-1:0] dmemRData,
   output logic stall,
   output logic outReq,
   output logic [rvPkg::XLEN-1:0] outData,
   input wire logic outAck,
   output logic inReq,
   input wire logic [rvPkg::XLEN-1:0] inData,
   input wire logic inAck
);
   import rvPkg::*;

   typedef enum logic [1:0] {idle, waitAck, waitRelease} ioStateT;

   ioStateT state;
   logic [XLEN-1:0] rom [IMEM_WORDS];
   logic [XLEN-1:0] ram [DMEM_WORDS];
   logic [XLEN-1:0] inWord;
   logic [DMEM_AW-1:0] dIdx;
   logic outSel, inSel, ioAccess, curAck;

   initial $readmemh("program.hex", rom);

   assign dIdx = dmemAddr[DMEM_AW+1:2];
   assign outSel = (dmemAddr == IO_OUT_ADDR);
   assign inSel = (dmemAddr == IO_IN_ADDR);
   assign ioAccess = (dmemWe && outSel) || (dmemRe && inSel);
   // Address stays put during the stall, so it picks the port to watch
   assign curAck = outSel ? outAck : inAck;

   assign stall = (state == idle && ioAccess) || (state == waitAck) ||
                  (state == waitRelease && curAck);

   // Frozen with the pipeline so execute keeps its instruction
   always_ff @(posedge clk)
   begin
      if (!stall)
         imemData <= rom[imemAddr[IMEM_AW+1:2]];
   end

   always_ff @(posedge clk)
   begin
      if (dmemWe && !outSel && !inSel)
         ram[dIdx] <= dmemWData;
      if (dmemRe && !stall)
         dmemRData <= inSel ? inWord : ram[dIdx];
   end

   // Four-phase handshake sequencer
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state <= idle;
         outReq <= 1'b0;
         inReq <= 1'b0;
      end
      else
      begin
         case (state)
            idle:
               if (ioAccess)
               begin
                  state <= waitAck;
                  outReq <= outSel;
                  inReq <= inSel;
               end
            waitAck:
               if (curAck)
               begin
                  state <= waitRelease;
                  outReq <= 1'b0;
                  inReq <= 1'b0;
               end
            default:
               if (!curAck)
                  state <= idle;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (state == idle && ioAccess && outSel)
         outData <= dmemWData;
      if (state == waitAck && inAck && inSel)
         inWord <= inData;
   end

endmodule

`default_nettype wire

// ==== hdl/rvSystem.sv ====
// ==================================================
// System top level
// RV32I core joined to its memory system
// ==================================================
`default_nettype none

module rvSystem (
   input wire logic clk,
   input wire logic rst,
   output logic outReq,
   output logic [rvPkg::XLEN-1:0] outData,
   input wire logic outAck,
   output logic inReq,
   input wire logic [rvPkg::XLEN-1:0] inData,
   input wire logic inAck
);
   import rvPkg::*;

   logic [XLEN-1:0] imemAddr, imemData;
   logic [XLEN-1:0] dmemAddr, dmemWData, dmemRData;
   logic dmemWe, dmemRe, stall;

   riscCore cpu (
      .clk(clk), .rst(rst),
      .imemAddr(imemAddr), .imemData(imemData),
      .dmemAddr(dmemAddr), .dmemWData(dmemWData), .dmemWe(dmemWe), .dmemRe(dmemRe),
      .dmemRData(dmemRData), .stall(stall)
   );

   memSystem mem (
      .clk(clk), .rst(rst),
      .imemAddr(imemAddr), .imemData(imemData),
      .dmemAddr(dmemAddr), .dmemWData(dmemWData), .dmemWe(dmemWe), .dmemRe(dmemRe),
      .dmemRData(dmemRData), .stall(stall),
      .outReq(outReq), .outData(outData), .outAck(outAck),
      .inReq(inReq), .inData(inData), .inAck(inAck)
   );

endmodule

`default_nettype wire

// ==== bench/rvSystemTb.sv ====
// ==================================================
// Testbench for the RV32I system
// Feeds input words, collects four outputs per word
// and compares them with the program's rules
// ==================================================
`default_nettype none

module rvSystemTb;
   import rvPkg::*;

   localparam int ENTRIES = 12;
   localparam int FIXED_COUNT = 6;
   localparam int OUTS = 4;
   localparam int RESET_CYCLES = 3;
   localparam int REQ_TIMEOUT = 5000;
   localparam int ACK_TIMEOUT = 20;
   localparam int RNG_SEED = 87;
   // Constant built by LUI, plus the PC of the AUIPC in program.hex
   localparam logic [XLEN-1:0] LUI_CONST = 32'h1234_5000;
   localparam logic [XLEN-1:0] AUIPC_PC = 32'h0000_0048;
   localparam logic [XLEN-1:0] FIXED_N [FIXED_COUNT] = '{
      32'd0, 32'd1, 32'd2, 32'd7, 32'd15, 32'd31
   };

   logic clk = 1'b0;
   logic rst;
   logic outReq, inReq;
   logic outAck, inAck;
   logic [XLEN-1:0] outData, inData;

   // Stimulus table, one input word and four expected outputs per entry
   logic [XLEN-1:0] inputTab [ENTRIES];
   logic [XLEN-1:0] expectTab [ENTRIES][OUTS];

   logic prevOutReq = 1'b0;
   logic prevInReq = 1'b0;
   logic [XLEN-1:0] heldOutData = '0;

   rvSystem rvSystem_inst (
      .clk(clk), .rst(rst),
      .outReq(outReq), .outData(outData), .outAck(outAck),
      .inReq(inReq), .inData(inData), .inAck(inAck)
   );

   always #2 clk = ~clk;

   task automatic abortRun();
      $display("TB FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic checkWord(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                            input string what);
      if (got !== exp)
      begin
         $display("FAILED at %0t: %s, got 0x%08h, expected 0x%08h", $time, what, got, exp);
         abortRun();
      end
   endtask

   task automatic checkFlag(input logic got, input logic exp, input string what);
      if (got !== exp)
      begin
         $display("FAILED at %0t: %s, got %b, expected %b", $time, what, got, exp);
         abortRun();
      end
   endtask

   task automatic checkCount(input int got, input int exp, input string what);
      if (got != exp)
      begin
         $display("FAILED at %0t: %s, got %0d outputs, expected %0d", $time, what, got, exp);
         abortRun();
      end
   endtask

   function automatic string outputName(input int idx);
      case (idx)
         0: return "sum of 1..n";
         1: return "(n << 2) ^ n";
         2: return "n < 40 by slt";
         default: return "LUI/AUIPC constant";
      endcase
   endfunction

   task automatic buildTable();
      int i;
      logic [XLEN-1:0] n;
      for (i = 0; i < ENTRIES; i++)
      begin
         if (i < FIXED_COUNT)
            n = FIXED_N[i];
         else
            n = $urandom % 64;
         inputTab[i] = n;
         expectTab[i][0] = n * (n + 32'd1) / 32'd2;
         expectTab[i][1] = (n << 2) ^ n;
         expectTab[i][2] = (n < 32'd40) ? 32'd1 : 32'd0;
         expectTab[i][3] = LUI_CONST + AUIPC_PC;
      end
   endtask

   // Returns at a falling edge with inReq or outReq high
   task automatic waitRequest();
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (!inReq && !outReq)
      begin
         cycles++;
         if (cycles > REQ_TIMEOUT)
         begin
            $display("Timeout: the system raised neither inReq nor outReq");
            abortRun();
         end
         @(negedge clk);
      end
   endtask

   task automatic serveInput(input logic [XLEN-1:0] n);
      int cycles;
      cycles = 0;
      while (!inReq)
      begin
         cycles++;
         if (cycles > REQ_TIMEOUT)
         begin
            $display("Timeout: input handshake hung waiting for inReq");
            abortRun();
         end
         @(negedge clk);
      end
      @(posedge clk);
      inData <= n;
      inAck <= 1'b1;
      cycles = 0;
      @(negedge clk);
      while (inReq)
      begin
         cycles++;
         if (cycles > ACK_TIMEOUT)
         begin
            $display("Timeout: input handshake hung, inReq stayed high after inAck");
            abortRun();
         end
         @(negedge clk);
      end
      @(posedge clk);
      inAck <= 1'b0;
   endtask

   task automatic takeOutput(output logic [XLEN-1:0] word);
      int delay;
      int d;
      int cycles;
      word = outData;
      // Random back-pressure of 0 to 5 cycles
      delay = int'($urandom % 6);
      for (d = 0; d < delay; d++)
         @(posedge clk);
      @(posedge clk);
      outAck <= 1'b1;
      cycles = 0;
      @(negedge clk);
      while (outReq)
      begin
         cycles++;
         if (cycles > ACK_TIMEOUT)
         begin
            $display("Timeout: output handshake hung, outReq stayed high after outAck");
            abortRun();
         end
         @(negedge clk);
      end
      @(posedge clk);
      outAck <= 1'b0;
   endtask

   // Four-phase ordering and data stability
   always @(negedge clk)
   begin
      if (!rst)
      begin
         if (prevOutReq && !outReq)
            checkFlag(outAck, 1'b1, "outAck high when outReq falls");
         if (prevInReq && !inReq)
            checkFlag(inAck, 1'b1, "inAck high when inReq falls");
         if (prevOutReq && outReq)
            checkWord(outData, heldOutData, "outData stable while outReq high");
      end
      prevOutReq = outReq;
      prevInReq = inReq;
      heldOutData = outData;
   end

   initial
   begin
      int i;
      int c;
      int count;
      logic done;
      logic [XLEN-1:0] word;
      rst <= 1'b1;
      outAck <= 1'b0;
      inAck <= 1'b0;
      inData <= '0;
      void'($urandom(RNG_SEED));
      buildTable();

      for (c = 0; c < RESET_CYCLES; c++)
      begin
         @(posedge clk);
         if (c == RESET_CYCLES - 1)
            rst <= 1'b0;
         @(negedge clk);
         checkFlag(outReq, 1'b0, "outReq low during reset");
         checkFlag(inReq, 1'b0, "inReq low during reset");
      end

      waitRequest();
      checkFlag(outReq, 1'b0, "no output before the first input request");
      checkFlag(inReq, 1'b1, "first request after reset is an input");

      for (i = 0; i < ENTRIES; i++)
      begin
         serveInput(inputTab[i]);
         count = 0;
         done = 1'b0;
         // Outputs end when the program asks for the next input
         while (!done)
         begin
            waitRequest();
            if (inReq)
               done = 1'b1;
            else
            begin
               takeOutput(word);
               if (count < OUTS)
                  checkWord(word, expectTab[i][count],
                            $sformatf("n=%0d %s", inputTab[i], outputName(count)));
               count++;
               if (count > OUTS)
                  checkCount(count, OUTS, $sformatf("extra output for n=%0d", inputTab[i]));
            end
         end
         checkCount(count, OUTS, $sformatf("outputs for n=%0d", inputTab[i]));
      end

      $display("TB PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== program.hex ====
// One instruction word per line, then its byte address and assembly
// IO base 0x80000000: output at offset 0, input at offset 4
80000537  // 00: lui   x10, 0x80000      IO base
00452083  // 04: lw    x1, 4(x10)        read n
00002023  // 08: sw    x0, 0(x0)         partial sum = 0
00008193  // 0C: addi  x3, x1, 0         i = n
00018C63  // 10: beq   x3, x0, 0x28      loop done when i = 0
00002103  // 14: lw    x2, 0(x0)         reload partial sum
00310133  // 18: add   x2, x2, x3        load-use
00202023  // 1C: sw    x2, 0(x0)         store partial sum
FFF18193  // 20: addi  x3, x3, -1
FEDFF06F  // 24: jal   x0, 0x10
00002103  // 28: lw    x2, 0(x0)
00252023  // 2C: sw    x2, 0(x10)        output sum
028002EF  // 30: jal   x5, 0x58          call subroutine
00452023  // 34: sw    x4, 0(x10)        output (n << 2) ^ n
FD808313  // 38: addi  x6, x1, -40
000323B3  // 3C: slt   x7, x6, x0
00752023  // 40: sw    x7, 0(x10)        output n < 40
123454B7  // 44: lui   x9, 0x12345
00000417  // 48: auipc x8, 0             x8 = 0x48
00848433  // 4C: add   x8, x9, x8        0x12345048
00852023  // 50: sw    x8, 0(x10)        output constant
FB1FF06F  // 54: jal   x0, 0x04          next input
00209213  // 58: slli  x4, x1, 2         subroutine
00124233  // 5C: xor   x4, x4, x1
00028067  // 60: jalr  x0, 0(x5)         return

// ==== sim.f ====
common/rvPkg.sv
hdl/regFile.sv
core/decoder.sv
core/aluUnit.sv
core/branchUnit.sv
core/riscCore.sv
hdl/memSystem.sv
hdl/rvSystem.sv
bench/rvSystemTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f sim.f --top-module rvSystemTb -o rvSystemSim
./obj_dir/rvSystemSim
